// File: source/dec_defines.svh
// Sizing macros for the AES-256 decryption core
`ifndef DEC_DEFINES_SVH
`define DEC_DEFINES_SVH

// Inverse rounds for AES-256
// 10 or 12 also work with a matching key table
`define DEC_ROUNDS 14

// One round key per round plus the initial AddRoundKey key
`define DEC_RK_DEPTH (`DEC_ROUNDS + 1)

// Cipher block width in bits
`define DEC_BLOCK_W 128

// Round index width, enough for 0 to DEC_ROUNDS
`define DEC_RK_AW 4

`endif

// File: source/aes_types_pkg.sv
// AES data types shared by the state path, key ROM and combiner
`include "dec_defines.svh"

package aes_types_pkg;

    // Bytes and 32-bit columns in one block
    localparam int NBYTES = `DEC_BLOCK_W / 8;
    localparam int NCOLS  = `DEC_BLOCK_W / 32;

    // State word seen two ways
    // Byte index is 4*col + row, byte 0 in the top bits (FIPS column-major)
    typedef union packed
    {
        // Byte view for shifting and substitution
        logic [0:NBYTES-1][7:0] bytes;
        // Column view for InvMixColumns, column 0 in the top word
        logic [0:NCOLS-1][31:0] cols;
    } aes_state_u;

    // Round key, byte order as in the state
    typedef logic [`DEC_BLOCK_W-1:0] round_key_t;

endpackage

// File: source/dec_ctrl_pkg.sv
// Control types for the decryption round sequencer
package dec_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0]
    {
        // Waiting for a block
        IDLE,
        // State path and key ROM register together
        SUBST,
        // Combiner registers
        COMBINE,
        // One cycle ahead of the result strobe
        DONE
    } seq_state_e;

    // Per-step control bundle
    typedef struct packed
    {
        // Take the input block instead of the round state
        logic load_sel;
        // InvMixColumns after the key XOR
        logic mix_en;
        // Combiner register enable
        logic comb_en;
        // State path and key ROM register enable
        logic path_en;
    } step_ctrl_t;

endpackage

// File: source/inv_sub_shift.sv
// State path: InvShiftRows then parallel InvSubBytes, registered on enable
`timescale 1ns/1ps

module inv_sub_shift
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      en,
    input  aes_types_pkg::aes_state_u state_in,
    output aes_types_pkg::aes_state_u state_out
);

    // Inverse S-box, entry 00 in the top byte
    localparam logic [2047:0] INV_SBOX =
    {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    aes_types_pkg::aes_state_u shifted;
    aes_types_pkg::aes_state_u subbed;

    // Table lookup, one byte in one byte out
    function automatic logic [7:0] inv_sbox(input logic [7:0] b);
        return INV_SBOX[2047 - 8 * int'(b) -: 8];
    endfunction

    // InvShiftRows through the byte view
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                // Row r turns right by r, so column c takes from column c - r
                shifted.bytes[4 * c + r] = state_in.bytes[4 * ((c - r + 4) % 4) + r];
            end
        end
    end

    // All sixteen bytes substituted at once
    always_comb
    begin
        for (int i = 0; i < aes_types_pkg::NBYTES; i++)
        begin
            subbed.bytes[i] = inv_sbox(shifted.bytes[i]);
        end
    end

    // Holds between steps
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_out <= '0;
        end
        else if (en)
        begin
            state_out <= subbed;
        end
    end

endmodule

// File: source/round_key_rom.sv
// Registered ROM of the AES-256 round keys for key 000102..1f
`timescale 1ns/1ps
`include "dec_defines.svh"

module round_key_rom
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      en,
    input  logic [`DEC_RK_AW-1:0]     round_idx,
    output aes_types_pkg::round_key_t round_key
);

    // Expanded schedule, entry n used in encryption round n
    function automatic aes_types_pkg::round_key_t rk_lookup(input logic [`DEC_RK_AW-1:0] idx);
        case (idx)
            0:       return 128'h000102030405060708090a0b0c0d0e0f;
            1:       return 128'h101112131415161718191a1b1c1d1e1f;
            2:       return 128'ha573c29fa176c498a97fce93a572c09c;
            3:       return 128'h1651a8cd0244beda1a5da4c10640bade;
            4:       return 128'hae87dff00ff11b68a68ed5fb03fc1567;
            5:       return 128'h6de1f1486fa54f9275f8eb5373b8518d;
            6:       return 128'hc656827fc9a799176f294cec6cd5598b;
            7:       return 128'h3de23a75524775e727bf9eb45407cf39;
            8:       return 128'h0bdc905fc27b0948ad5245a4c1871c2f;
            9:       return 128'h45f5a66017b2d387300d4d33640a820a;
            10:      return 128'h7ccff71cbeb4fe5413e6bbf0d261a7df;
            11:      return 128'hf01afafee7a82979d7a5644ab3afe640;
            12:      return 128'h2541fe719bf500258813bbd55a721c0a;
            13:      return 128'h4e5a6699a9f24fe07e572baacdf8cdea;
            14:      return 128'h24fc79ccbf0979e9371ac23c6d68de36;
            default: return '0;
        endcase
    endfunction

    // Read on the path enable, which is also high while idle
    // so the last key is already waiting for step 0
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            round_key <= '0;
        end
        else if (en && (round_idx < `DEC_RK_DEPTH))
        begin
            round_key <= rk_lookup(round_idx);
        end
    end

endmodule

// File: source/key_mix_combine.sv
// Combiner: AddRoundKey on the load or round state, then optional InvMixColumns
`timescale 1ns/1ps

module key_mix_combine
(
    input  logic                      clk,
    input  logic                      resetn,
    input  dec_ctrl_pkg::step_ctrl_t  ctrl,
    input  aes_types_pkg::aes_state_u load_block,
    input  aes_types_pkg::aes_state_u round_state,
    input  aes_types_pkg::round_key_t round_key,
    output aes_types_pkg::aes_state_u state_out
);

    aes_types_pkg::aes_state_u load_q;
    aes_types_pkg::aes_state_u keyed;
    aes_types_pkg::aes_state_u mixed;

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a 4-bit constant, shift and add
    function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] k);
        logic [7:0] acc;
        logic [7:0] p;
        acc = '0;
        p = b;
        for (int i = 0; i < 4; i++)
        begin
            if (k[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // One column through the inverse mix matrix, row 0 in the top byte
    function automatic logic [31:0] inv_mix_col(input logic [31:0] col);
        logic [0:3][7:0] a;
        logic [0:3][7:0] m;
        a = col;
        for (int r = 0; r < 4; r++)
        begin
            // Row r of the circulant 0e 0b 0d 09, turned right by r
            m[r] = gf_mul(a[r], 4'd14) ^ gf_mul(a[(r + 1) % 4], 4'd11)
                 ^ gf_mul(a[(r + 2) % 4], 4'd13) ^ gf_mul(a[(r + 3) % 4], 4'd9);
        end
        return m;
    endfunction

    // Track the input while idle, frozen once the first step starts
    always_ff @(posedge clk)
    begin
        if (ctrl.load_sel && !ctrl.comb_en)
            load_q <= load_block;
    end

    always_comb
    begin
        keyed = (ctrl.load_sel ? load_q : round_state) ^ round_key;
        for (int c = 0; c < aes_types_pkg::NCOLS; c++)
        begin
            mixed.cols[c] = inv_mix_col(keyed.cols[c]);
        end
    end

    // Round state register, also the core output
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state_out <= '0;
        else if (ctrl.comb_en)
            state_out <= ctrl.mix_en ? mixed : keyed;
    end

endmodule

// File: source/dec_round_ctrl.sv
// Round sequencer: steps through load, inverse rounds and result strobe
`timescale 1ns/1ps
`include "dec_defines.svh"

module dec_round_ctrl
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    output dec_ctrl_pkg::step_ctrl_t ctrl,
    output logic [`DEC_RK_AW-1:0]    round_idx,
    output logic                     out_valid,
    output logic                     busy
);

    // Final step number, also the first key read
    localparam logic [`DEC_RK_AW-1:0] LAST_STEP = `DEC_RK_AW'(`DEC_ROUNDS);

    dec_ctrl_pkg::seq_state_e state;
    dec_ctrl_pkg::seq_state_e state_next;
    logic [`DEC_RK_AW-1:0]    step;
    logic [`DEC_RK_AW-1:0]    step_next;

    // Keys are consumed from the top down
    assign round_idx = LAST_STEP - step;

    always_comb
    begin
        state_next = state;
        step_next = step;
        case (state)
            dec_ctrl_pkg::IDLE:
            begin
                // Strobes outside IDLE are dropped
                if (in_valid)
                    state_next = dec_ctrl_pkg::COMBINE;
            end
            dec_ctrl_pkg::SUBST:
            begin
                state_next = dec_ctrl_pkg::COMBINE;
            end
            dec_ctrl_pkg::COMBINE:
            begin
                if (step == LAST_STEP)
                begin
                    state_next = dec_ctrl_pkg::DONE;
                end
                else
                begin
                    state_next = dec_ctrl_pkg::SUBST;
                    step_next = step + 1'b1;
                end
            end
            default:
            begin
                state_next = dec_ctrl_pkg::IDLE;
                step_next = '0;
            end
        endcase
    end

    // Control decode from registered state only
    always_comb
    begin
        ctrl = '0;
        case (state)
            dec_ctrl_pkg::IDLE:
            begin
                // Track the input block, prime the last key
                ctrl.load_sel = 1'b1;
                ctrl.path_en = 1'b1;
            end
            dec_ctrl_pkg::SUBST:
            begin
                ctrl.path_en = 1'b1;
            end
            dec_ctrl_pkg::COMBINE:
            begin
                ctrl.comb_en = 1'b1;
                ctrl.load_sel = (step == '0);
                // No mix on the whitening step or the final round
                ctrl.mix_en = (step != '0) && (step != LAST_STEP);
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= dec_ctrl_pkg::IDLE;
            step <= '0;
            out_valid <= 1'b0;
            busy <= 1'b0;
        end
        else
        begin
            state <= state_next;
            step <= step_next;
            // One cycle behind DONE, result already held
            out_valid <= (state == dec_ctrl_pkg::DONE);
            // Lags the state by a cycle, drops together with the strobe
            busy <= (state == dec_ctrl_pkg::SUBST) || (state == dec_ctrl_pkg::COMBINE);
        end
    end

endmodule

// File: source/aes256_dec_core.sv
// AES-256 iterative decryption core for one fixed key
`timescale 1ns/1ps
`include "dec_defines.svh"

module aes256_dec_core
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      in_valid,
    input  aes_types_pkg::aes_state_u in_block,
    output logic                      out_valid,
    output aes_types_pkg::aes_state_u out_block,
    output logic                      busy
);

    dec_ctrl_pkg::step_ctrl_t  ctrl;
    logic [`DEC_RK_AW-1:0]     round_idx;
    aes_types_pkg::aes_state_u sub_state;
    aes_types_pkg::round_key_t round_key;

    // Sequencer
    dec_round_ctrl u_ctrl
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .ctrl      (ctrl),
        .round_idx (round_idx),
        .out_valid (out_valid),
        .busy      (busy)
    );

    // State path, fed back from the combiner
    inv_sub_shift u_sub_shift
    (
        .clk       (clk),
        .resetn    (resetn),
        .en        (ctrl.path_en),
        .state_in  (out_block),
        .state_out (sub_state)
    );

    // Key path, same enable as the state path
    round_key_rom u_key_rom
    (
        .clk       (clk),
        .resetn    (resetn),
        .en        (ctrl.path_en),
        .round_idx (round_idx),
        .round_key (round_key)
    );

    // Joins both paths, its register is the output block
    key_mix_combine u_combine
    (
        .clk         (clk),
        .resetn      (resetn),
        .ctrl        (ctrl),
        .load_block  (in_block),
        .round_state (sub_state),
        .round_key   (round_key),
        .state_out   (out_block)
    );

endmodule

// File: tests/tb_vectors.svh
// Stimulus and expected-value table for the AES-256 decryption testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// FIPS-197 appendix C.3 pair for key 000102..1f
localparam logic [`DEC_BLOCK_W-1:0] C3_CIPHER = 128'h8ea2b7ca516745bfeafc49904b496089;
localparam logic [`DEC_BLOCK_W-1:0] C3_PLAIN  = 128'h00112233445566778899aabbccddeeff;

// Columns: ciphertext, expected plaintext, max idle gap, strobe while busy
// A gap of 0 applies the block in the cycle busy falls
// Any other gap is drawn at random from 1 to max
typedef struct packed
{
    logic [`DEC_BLOCK_W-1:0] cipher;
    logic [`DEC_BLOCK_W-1:0] plain;
    logic [7:0]              max_gap;
    logic                    drop_strobe;
} vec_row_t;

localparam int NUM_VECS = 6;

localparam vec_row_t VEC_TABLE [0:NUM_VECS-1] = '{
    '{C3_CIPHER, C3_PLAIN, 8'd3,  1'b0},
    '{C3_CIPHER, C3_PLAIN, 8'd0,  1'b0},
    '{C3_CIPHER, C3_PLAIN, 8'd0,  1'b1},
    '{C3_CIPHER, C3_PLAIN, 8'd7,  1'b0},
    '{C3_CIPHER, C3_PLAIN, 8'd12, 1'b1},
    '{C3_CIPHER, C3_PLAIN, 8'd0,  1'b0}
};

`endif

// File: tests/tb_aes256_dec.sv
// Table-driven testbench for the AES-256 decryption core with timing checks
`timescale 1ns/1ps
`include "dec_defines.svh"

module tb_aes256_dec;

    // Sampling edge to result strobe
    localparam int LATENCY = 2 * `DEC_ROUNDS + 2;
    // Bound on every wait loop
    localparam int TIMEOUT_CYCLES = 4 * LATENCY;
    localparam int DRIVE_DELAY = 1;

    `include "tb_vectors.svh"

    logic                      clk;
    logic                      resetn;
    logic                      in_valid;
    aes_types_pkg::aes_state_u in_block;
    logic                      out_valid;
    aes_types_pkg::aes_state_u out_block;
    logic                      busy;

    int error_count;
    // Every out_valid cycle seen, and the number that should have been seen
    int pulse_count;
    int expected_pulses;

    aes256_dec_core DUT
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_block  (in_block),
        .out_valid (out_valid),
        .out_block (out_block),
        .busy      (busy)
    );

    // 100 ns period
    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Moves to just after the next rising edge, where outputs are settled
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        pulse_count += int'(out_valid);
    endtask

    task automatic check_value(input string name, input logic [`DEC_BLOCK_W-1:0] expected,
                               input logic [`DEC_BLOCK_W-1:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("Fail %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    // Reset values must show during and right after reset
    task automatic hold_reset(input int cycles);
        resetn = 1'b0;
        for (int i = 0; i <= cycles; i++)
        begin
            if (i == cycles)
                resetn = 1'b1;
            next_cycle();
            check_value("out_valid", 128'(0), 128'(out_valid));
            check_value("busy", 128'(0), 128'(busy));
            check_value("out_block", 128'(0), out_block);
        end
    endtask

    // Nothing may come out of an idle core
    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            next_cycle();
            check_value("busy", 128'(0), 128'(busy));
            check_value("out_valid", 128'(0), 128'(out_valid));
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT_CYCLES)
        begin
            next_cycle();
            n++;
        end
        if (busy)
        begin
            error_count++;
            $display("Timeout: busy never fell before the next block was due");
        end
    endtask

    // One block from strobe to result that ends in the out_valid cycle
    task automatic decode_block(input logic [`DEC_BLOCK_W-1:0] cipher,
                                input logic [`DEC_BLOCK_W-1:0] plain,
                                input logic drop_strobe);
        int  n;
        int  start_pulses;
        bit  seen;
        wait_idle();
        start_pulses = pulse_count;
        in_valid = 1'b1;
        in_block = cipher;
        next_cycle();
        // Busy only rises one cycle after the accepting edge
        check_value("busy", 128'(0), 128'(busy));
        // Block is taken on that edge, so the bus may change now
        in_valid = 1'b0;
        in_block = {$urandom, $urandom, $urandom, $urandom};
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT_CYCLES)
        begin
            next_cycle();
            n++;
            if (out_valid)
            begin
                seen = 1'b1;
            end
            else
            begin
                check_value("busy", 128'(1), 128'(busy));
                // Foreign block for one cycle while busy
                in_valid = drop_strobe && (n == 5);
                if (in_valid)
                    in_block = ~cipher;
            end
        end
        in_valid = 1'b0;
        if (!seen)
        begin
            error_count++;
            $display("Timeout: out_valid never rose within %0d cycles of the accepted block",
                     TIMEOUT_CYCLES);
        end
        else
        begin
            check_value("latency", 128'(LATENCY), 128'(n));
            check_value("busy", 128'(0), 128'(busy));
            check_value("out_block", plain, out_block);
            check_value("out_valid pulses", 128'(1), 128'(pulse_count - start_pulses));
            expected_pulses++;
        end
    endtask

    initial
    begin
        vec_row_t row;
        int       gap_cycles;
        error_count = 0;
        pulse_count = 0;
        expected_pulses = 0;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_block = '0;
        void'($urandom(32'h427d39e1));

        hold_reset(10);

        // Table rows applied back to back or after random idle gaps
        for (int i = 0; i < NUM_VECS; i++)
        begin
            row = VEC_TABLE[i];
            gap_cycles = 0;
            if (row.max_gap != 0)
                gap_cycles = 1 + int'($urandom % 32'(row.max_gap));
            repeat (gap_cycles) next_cycle();
            decode_block(row.cipher, row.plain, row.drop_strobe);
        end
        expect_quiet(LATENCY + 4);

        // Reset in the middle of a block
        wait_idle();
        in_valid = 1'b1;
        in_block = VEC_TABLE[0].cipher;
        next_cycle();
        in_valid = 1'b0;
        repeat (11) next_cycle();
        check_value("busy", 128'(1), 128'(busy));
        resetn = 1'b0;
        #DRIVE_DELAY;
        // Asynchronous clear needs no edge
        check_value("busy", 128'(0), 128'(busy));
        hold_reset(3);
        expect_quiet(LATENCY + 4);

        // Core must work again after that reset
        decode_block(VEC_TABLE[0].cipher, VEC_TABLE[0].plain, 1'b0);
        expect_quiet(LATENCY + 4);
        check_value("out_valid total", 128'(expected_pulses), 128'(pulse_count));

        $display("Summary: %0d errors, %0d blocks decoded, %0d out_valid pulses",
                 error_count, expected_pulses, pulse_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
+incdir+tests
source/aes_types_pkg.sv
source/dec_ctrl_pkg.sv
source/inv_sub_shift.sv
source/round_key_rom.sv
source/key_mix_combine.sv
source/dec_round_ctrl.sv
source/aes256_dec_core.sv
tests/tb_aes256_dec.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timescale 1ns/1ps -Wno-fatal -f all.f \
    --top-module tb_aes256_dec -o tb_aes256_dec \
    && ./obj_dir/tb_aes256_dec > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^SIMULATION PASSED$" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
